/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary -j 0
TOP ?= tb_rob
FLIST ?= flist.f
OBJ_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/branch_resolve.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module branch_resolve (
	input  logic                  wb_valid_i,
	input  rob_pkg::unit_e        wb_unit_i,
	input  logic [`ROB_TAG_W-1:0] wb_tag_i,
	input  rob_pkg::cpl_data_u    wb_data_i,
	input  rob_pkg::rob_entry_t   wb_entry_i,
	output logic                  flush_o,
	output logic [`ROB_TAG_W-1:0] flush_tag_o,
	output logic [`ROB_XLEN-1:0]  flush_pc_o
);
	logic                 br_wb;
	logic                 is_cond;
	logic                 is_jalr;
	logic                 taken;
	logic                 mispredict;
	logic [`ROB_XLEN-1:0] fall_through;

	// only a live entry completed by the branch unit can redirect
	assign br_wb = wb_valid_i && (wb_unit_i == rob_pkg::unit_br) && wb_entry_i.valid;

	assign is_cond = wb_entry_i.opcode == rob_pkg::op_br;
	assign is_jalr = wb_entry_i.opcode == rob_pkg::op_jalr;

	// outcome view for conditional branches
	assign taken      = wb_data_i.outcome.taken;
	assign mispredict = is_cond && (taken != wb_entry_i.br_pred);

	assign fall_through = wb_entry_i.pc + 4;

	// jalr target is never predicted, so it always redirects
	assign flush_o = br_wb && (mispredict || is_jalr);

	// first younger tag, wraps at the depth
	assign flush_tag_o = wb_tag_i + 1'b1;

	always_comb begin
		if (is_jalr) begin
			flush_pc_o = wb_data_i.value;
		end else if (taken) begin
			flush_pc_o = wb_entry_i.target;
		end else begin
			flush_pc_o = fall_through;
		end
	end

endmodule

/* design/completion_arbiter.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module completion_arbiter (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  acu_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] acu_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  acu_cpl_data_i,
	input  logic                  br_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] br_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  br_cpl_data_i,
	input  logic                  lsq_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] lsq_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  lsq_cpl_data_i,
	output logic                  acu_cpl_ready_o,
	output logic                  br_cpl_ready_o,
	output logic                  lsq_cpl_ready_o,
	output logic                  wb_valid_o,
	output logic [`ROB_TAG_W-1:0] wb_tag_o,
	output rob_pkg::cpl_data_u    wb_data_o,
	output rob_pkg::unit_e        wb_unit_o
);
	localparam int NUM_UNITS = 3;

	logic [NUM_UNITS-1:0]  req;
	logic [`ROB_TAG_W-1:0] tag_in [NUM_UNITS];
	logic [`ROB_XLEN-1:0]  data_in [NUM_UNITS];
	// unit with the highest priority this cycle
	logic [1:0]            prio;
	logic [1:0]            scan_idx;
	logic [1:0]            grant_idx;
	logic                  grant_vld;

	function automatic logic [1:0] next_unit(input logic [1:0] idx);
		return (idx == 2'(NUM_UNITS - 1)) ? 2'd0 : idx + 2'd1;
	endfunction

	// requests indexed by unit encoding
	always_comb begin
		req[rob_pkg::unit_br]      = br_cpl_valid_i;
		req[rob_pkg::unit_acu]     = acu_cpl_valid_i;
		req[rob_pkg::unit_lsq]     = lsq_cpl_valid_i;
		tag_in[rob_pkg::unit_br]   = br_cpl_tag_i;
		tag_in[rob_pkg::unit_acu]  = acu_cpl_tag_i;
		tag_in[rob_pkg::unit_lsq]  = lsq_cpl_tag_i;
		data_in[rob_pkg::unit_br]  = br_cpl_data_i;
		data_in[rob_pkg::unit_acu] = acu_cpl_data_i;
		data_in[rob_pkg::unit_lsq] = lsq_cpl_data_i;
	end

	// first requester found walking from prio
	always_comb begin
		scan_idx  = prio;
		grant_vld = 1'b0;
		grant_idx = prio;
		for (int i = 0; i < NUM_UNITS; i++) begin
			if (!grant_vld && req[scan_idx]) begin
				grant_vld = 1'b1;
				grant_idx = scan_idx;
			end
			scan_idx = next_unit(scan_idx);
		end
	end

	// winner drops to lowest priority
	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= 2'd0;
		end else if (grant_vld) begin
			prio <= next_unit(grant_idx);
		end
	end

	assign br_cpl_ready_o  = grant_vld && (grant_idx == rob_pkg::unit_br);
	assign acu_cpl_ready_o = grant_vld && (grant_idx == rob_pkg::unit_acu);
	assign lsq_cpl_ready_o = grant_vld && (grant_idx == rob_pkg::unit_lsq);

	assign wb_valid_o      = grant_vld;
	assign wb_tag_o        = tag_in[grant_idx];
	assign wb_data_o.value = data_in[grant_idx];
	assign wb_unit_o       = rob_pkg::unit_e'(grant_idx);

endmodule

/* design/dispatch_ctrl.sv */
`timescale 1ns/1ps

module dispatch_ctrl (
	input  logic             clk,
	input  logic             rst,
	input  logic             iq_valid_i,
	input  rob_pkg::opcode_e iq_opcode_i,
	input  logic             stall_br_i,
	input  logic             stall_acu_i,
	input  logic             stall_lsq_i,
	input  logic             full_i,
	input  logic             head_commit_i,
	input  logic             flush_i,
	output logic             iq_deq_o,
	output logic             load_br_o,
	output logic             load_acu_o,
	output logic             load_lsq_o,
	output logic             reg_write_o,
	output logic             enq_o
);
	rob_pkg::unit_e unit;
	logic           known;
	logic           stalled;
	logic           writes_rd;
	logic           room;
	logic           active;
	logic           accept;

	// storage is still clearing during reset, so hold off for one cycle after it
	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
		end else begin
			active <= 1'b1;
		end
	end

	// opcode routing table
	always_comb begin
		unit  = rob_pkg::unit_acu;
		known = 1'b1;
		case (iq_opcode_i)
			rob_pkg::op_br, rob_pkg::op_jal, rob_pkg::op_jalr: unit = rob_pkg::unit_br;
			rob_pkg::op_load, rob_pkg::op_store: unit = rob_pkg::unit_lsq;
			rob_pkg::op_lui, rob_pkg::op_auipc,
			rob_pkg::op_imm, rob_pkg::op_reg: unit = rob_pkg::unit_acu;
			default: known = 1'b0;
		endcase
	end

	always_comb begin
		case (unit)
			rob_pkg::unit_br:  stalled = stall_br_i;
			rob_pkg::unit_lsq: stalled = stall_lsq_i;
			default:           stalled = stall_acu_i;
		endcase
	end

	// branches and stores leave the register file alone
	assign writes_rd = (iq_opcode_i != rob_pkg::op_br) && (iq_opcode_i != rob_pkg::op_store);

	// a full buffer still takes one if the head leaves this cycle
	assign room   = !full_i || head_commit_i;
	assign accept = active && iq_valid_i && known && !stalled && room && !flush_i;

	assign iq_deq_o    = accept;
	assign enq_o       = accept;
	assign load_br_o   = accept && (unit == rob_pkg::unit_br);
	assign load_acu_o  = accept && (unit == rob_pkg::unit_acu);
	assign load_lsq_o  = accept && (unit == rob_pkg::unit_lsq);
	assign reg_write_o = accept && writes_rd;

endmodule

/* design/rob_pkg.sv */
`include "rob_cfg.svh"

package rob_pkg;

	// RV32I major opcodes, bits [6:0] of the instruction word
	typedef enum logic [`ROB_OPC_W-1:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} opcode_e;

	// reservation station that receives a dispatched instruction
	typedef enum logic [1:0] {
		unit_br  = 2'd0,
		unit_acu = 2'd1,
		unit_lsq = 2'd2
	} unit_e;

	// one reorder buffer slot
	typedef struct packed {
		logic                 valid;
		logic                 rdy;
		opcode_e              opcode;
		logic [4:0]           rd;
		logic [`ROB_XLEN-1:0] pc;
		logic                 br_pred;
		// predicted-taken target
		logic [`ROB_XLEN-1:0] target;
		logic [`ROB_XLEN-1:0] data;
	} rob_entry_t;

	// completion word, either a result or a branch outcome
	typedef union packed {
		logic [`ROB_XLEN-1:0] value;
		struct packed {
			logic [`ROB_XLEN-2:0] pad;
			logic                 taken;
		} outcome;
	} cpl_data_u;

endpackage

/* design/rob_storage.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_storage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  enq_i,
	input  logic [`ROB_XLEN-1:0]  iq_pc_i,
	input  rob_pkg::opcode_e      iq_opcode_i,
	input  logic [4:0]            iq_rd_i,
	input  logic                  iq_br_pred_i,
	input  logic [`ROB_XLEN-1:0]  iq_target_i,
	input  logic                  wb_valid_i,
	input  logic [`ROB_TAG_W-1:0] wb_tag_i,
	input  rob_pkg::cpl_data_u    wb_data_i,
	input  logic                  flush_i,
	input  logic [`ROB_TAG_W-1:0] flush_tag_i,
	output logic [`ROB_TAG_W-1:0] dispatch_tag_o,
	output logic                  full_o,
	output logic                  head_commit_o,
	output logic [`ROB_TAG_W:0]   free_count_o,
	output rob_pkg::rob_entry_t   wb_entry_o,
	output logic                  commit_valid_o,
	output logic [`ROB_TAG_W-1:0] commit_tag_o,
	output logic [4:0]            commit_rd_o,
	output logic [`ROB_XLEN-1:0]  commit_data_o,
	output logic                  commit_we_o,
	output logic                  bcast_valid_o,
	output logic [`ROB_TAG_W-1:0] bcast_tag_o,
	output logic [`ROB_XLEN-1:0]  bcast_data_o
);
	localparam int DEPTH = `ROB_DEPTH;
	localparam int TAG_W = `ROB_TAG_W;

	rob_pkg::rob_entry_t  ent [DEPTH];
	rob_pkg::rob_entry_t  head_ent;
	logic [TAG_W-1:0]     head;
	logic [TAG_W-1:0]     tail;
	logic [TAG_W:0]       count;
	logic [TAG_W:0]       count_n;
	logic                 commit;
	logic                 wb_hit;
	logic                 wb_link;
	logic [`ROB_XLEN-1:0] wb_rec;
	// number of entries from flush_tag_i up to the tail
	logic [TAG_W-1:0]     kill_span;
	logic [TAG_W-1:0]     kill_off [DEPTH];
	logic                 kill [DEPTH];

	assign head_ent = ent[head];
	assign commit   = head_ent.valid && head_ent.rdy;

	assign dispatch_tag_o = tail;
	assign full_o         = count == (TAG_W + 1)'(DEPTH);
	assign head_commit_o  = commit;
	assign free_count_o   = (TAG_W + 1)'(DEPTH) - count;

	assign commit_valid_o = commit;
	assign commit_tag_o   = head;
	assign commit_rd_o    = head_ent.rd;
	assign commit_data_o  = head_ent.data;
	assign commit_we_o    = commit && (head_ent.opcode != rob_pkg::op_br) &&
		(head_ent.opcode != rob_pkg::op_store);

	// writeback side
	assign wb_entry_o = ent[wb_tag_i];
	assign wb_hit     = wb_valid_i && wb_entry_o.valid;
	assign wb_link    = (wb_entry_o.opcode == rob_pkg::op_jal) ||
		(wb_entry_o.opcode == rob_pkg::op_jalr);
	// jal and jalr write the return address, not the unit result
	assign wb_rec     = wb_link ? wb_entry_o.pc + 4 : wb_data_i.value;

	// conditional branches carry only a taken bit, nothing to forward
	assign bcast_valid_o = wb_hit && (wb_entry_o.opcode != rob_pkg::op_br);
	assign bcast_tag_o   = wb_tag_i;
	assign bcast_data_o  = wb_rec;

	// tags wrap at the depth, so plain subtraction gives ring distance
	assign kill_span = tail - flush_tag_i;

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			kill_off[i] = TAG_W'(i) - flush_tag_i;
			kill[i]     = flush_i && (kill_off[i] < kill_span);
		end
	end

	always_comb begin
		count_n = count;
		if (enq_i) begin
			count_n = count_n + 1'b1;
		end
		if (commit) begin
			count_n = count_n - 1'b1;
		end
		if (flush_i) begin
			count_n = count_n - {1'b0, kill_span};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				ent[i].valid <= 1'b0;
				ent[i].rdy   <= 1'b0;
			end
		end else begin
			count <= count_n;
			if (commit) begin
				ent[head].valid <= 1'b0;
				ent[head].rdy   <= 1'b0;
				head            <= head + 1'b1;
			end
			if (wb_hit) begin
				ent[wb_tag_i].rdy  <= 1'b1;
				ent[wb_tag_i].data <= wb_rec;
			end
			// drop everything younger than the redirecting branch
			for (int i = 0; i < DEPTH; i++) begin
				if (kill[i]) begin
					ent[i].valid <= 1'b0;
					ent[i].rdy   <= 1'b0;
				end
			end
			if (flush_i) begin
				tail <= flush_tag_i;
			end else if (enq_i) begin
				// tail slot may be the head leaving this cycle, so enqueue wins
				ent[tail] <= '{
					valid:   1'b1,
					rdy:     1'b0,
					opcode:  iq_opcode_i,
					rd:      iq_rd_i,
					pc:      iq_pc_i,
					br_pred: iq_br_pred_i,
					target:  iq_target_i,
					data:    '0
				};
				tail <= tail + 1'b1;
			end
		end
	end

endmodule

/* design/rob_top.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module rob_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  iq_valid_i,
	input  rob_pkg::opcode_e      iq_opcode_i,
	input  logic [`ROB_XLEN-1:0]  iq_pc_i,
	input  logic [4:0]            iq_rd_i,
	input  logic                  iq_br_pred_i,
	input  logic [`ROB_XLEN-1:0]  iq_target_i,
	input  logic                  stall_br_i,
	input  logic                  stall_acu_i,
	input  logic                  stall_lsq_i,
	output logic                  iq_deq_o,
	output logic                  load_br_o,
	output logic                  load_acu_o,
	output logic                  load_lsq_o,
	output logic                  reg_write_o,
	output logic [`ROB_TAG_W-1:0] dispatch_tag_o,
	output logic [`ROB_TAG_W:0]   free_count_o,
	input  logic                  acu_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] acu_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  acu_cpl_data_i,
	output logic                  acu_cpl_ready_o,
	input  logic                  br_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] br_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  br_cpl_data_i,
	output logic                  br_cpl_ready_o,
	input  logic                  lsq_cpl_valid_i,
	input  logic [`ROB_TAG_W-1:0] lsq_cpl_tag_i,
	input  logic [`ROB_XLEN-1:0]  lsq_cpl_data_i,
	output logic                  lsq_cpl_ready_o,
	output logic                  bcast_valid_o,
	output logic [`ROB_TAG_W-1:0] bcast_tag_o,
	output logic [`ROB_XLEN-1:0]  bcast_data_o,
	output logic                  commit_valid_o,
	output logic [`ROB_TAG_W-1:0] commit_tag_o,
	output logic [4:0]            commit_rd_o,
	output logic [`ROB_XLEN-1:0]  commit_data_o,
	output logic                  commit_we_o,
	output logic                  flush_o,
	output logic [`ROB_XLEN-1:0]  flush_pc_o
);
	logic                  enq;
	logic                  full;
	logic                  head_commit;
	logic [`ROB_TAG_W-1:0] flush_tag;
	// internal writeback bus
	logic                  wb_valid;
	logic [`ROB_TAG_W-1:0] wb_tag;
	rob_pkg::cpl_data_u    wb_data;
	rob_pkg::unit_e        wb_unit;
	rob_pkg::rob_entry_t   wb_entry;

	dispatch_ctrl dispatch_ctrl_inst (
		.clk           (clk),
		.rst           (rst),
		.iq_valid_i    (iq_valid_i),
		.iq_opcode_i   (iq_opcode_i),
		.stall_br_i    (stall_br_i),
		.stall_acu_i   (stall_acu_i),
		.stall_lsq_i   (stall_lsq_i),
		.full_i        (full),
		.head_commit_i (head_commit),
		.flush_i       (flush_o),
		.iq_deq_o      (iq_deq_o),
		.load_br_o     (load_br_o),
		.load_acu_o    (load_acu_o),
		.load_lsq_o    (load_lsq_o),
		.reg_write_o   (reg_write_o),
		.enq_o         (enq)
	);

	completion_arbiter completion_arbiter_inst (
		.clk             (clk),
		.rst             (rst),
		.acu_cpl_valid_i (acu_cpl_valid_i),
		.acu_cpl_tag_i   (acu_cpl_tag_i),
		.acu_cpl_data_i  (acu_cpl_data_i),
		.br_cpl_valid_i  (br_cpl_valid_i),
		.br_cpl_tag_i    (br_cpl_tag_i),
		.br_cpl_data_i   (br_cpl_data_i),
		.lsq_cpl_valid_i (lsq_cpl_valid_i),
		.lsq_cpl_tag_i   (lsq_cpl_tag_i),
		.lsq_cpl_data_i  (lsq_cpl_data_i),
		.acu_cpl_ready_o (acu_cpl_ready_o),
		.br_cpl_ready_o  (br_cpl_ready_o),
		.lsq_cpl_ready_o (lsq_cpl_ready_o),
		.wb_valid_o      (wb_valid),
		.wb_tag_o        (wb_tag),
		.wb_data_o       (wb_data),
		.wb_unit_o       (wb_unit)
	);

	rob_storage rob_storage_inst (
		.clk            (clk),
		.rst            (rst),
		.enq_i          (enq),
		.iq_pc_i        (iq_pc_i),
		.iq_opcode_i    (iq_opcode_i),
		.iq_rd_i        (iq_rd_i),
		.iq_br_pred_i   (iq_br_pred_i),
		.iq_target_i    (iq_target_i),
		.wb_valid_i     (wb_valid),
		.wb_tag_i       (wb_tag),
		.wb_data_i      (wb_data),
		.flush_i        (flush_o),
		.flush_tag_i    (flush_tag),
		.dispatch_tag_o (dispatch_tag_o),
		.full_o         (full),
		.head_commit_o  (head_commit),
		.free_count_o   (free_count_o),
		.wb_entry_o     (wb_entry),
		.commit_valid_o (commit_valid_o),
		.commit_tag_o   (commit_tag_o),
		.commit_rd_o    (commit_rd_o),
		.commit_data_o  (commit_data_o),
		.commit_we_o    (commit_we_o),
		.bcast_valid_o  (bcast_valid_o),
		.bcast_tag_o    (bcast_tag_o),
		.bcast_data_o   (bcast_data_o)
	);

	branch_resolve branch_resolve_inst (
		.wb_valid_i  (wb_valid),
		.wb_unit_i   (wb_unit),
		.wb_tag_i    (wb_tag),
		.wb_data_i   (wb_data),
		.wb_entry_i  (wb_entry),
		.flush_o     (flush_o),
		.flush_tag_o (flush_tag),
		.flush_pc_o  (flush_pc_o)
	);

endmodule

/* flist.f */
+incdir+include
design/rob_pkg.sv
design/dispatch_ctrl.sv
design/completion_arbiter.sv
design/rob_storage.sv
design/branch_resolve.sv
design/rob_top.sv
tb/tb_rob.sv

/* include/rob_cfg.svh */
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// number of buffer entries, kept a power of two so tags wrap on their own
`define ROB_DEPTH 8

// tag names one entry
`define ROB_TAG_W 3

// data and pc width
`define ROB_XLEN 32

// major opcode field of an RV32I instruction
`define ROB_OPC_W 7

`endif

/* tb/tb_rob.sv */
`timescale 1ns/1ps
`include "rob_cfg.svh"

module tb_rob;
	localparam int DEPTH = `ROB_DEPTH;
	localparam int XLEN = `ROB_XLEN;
	localparam int TAG_W = `ROB_TAG_W;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 400;
	localparam int PERIOD = 100;

	logic clk;
	logic rst;
	logic iq_valid_i;
	rob_pkg::opcode_e iq_opcode_i;
	logic [XLEN-1:0] iq_pc_i;
	logic [4:0] iq_rd_i;
	logic iq_br_pred_i;
	logic [XLEN-1:0] iq_target_i;
	logic stall_i [3];
	logic iq_deq_o, reg_write_o, load_o [3];
	logic [TAG_W-1:0] dispatch_tag_o;
	logic [TAG_W:0] free_count_o;
	// completion ports indexed by unit code (0 br, 1 acu, 2 lsq)
	logic u_valid [3];
	logic [TAG_W-1:0] u_tag [3];
	logic [XLEN-1:0] u_data [3];
	logic u_ready [3];
	logic u_accepted [3];
	logic [TAG_W+XLEN-1:0] cpl_q [3][$];
	logic bcast_valid_o, commit_valid_o, commit_we_o, flush_o;
	logic [TAG_W-1:0] bcast_tag_o, commit_tag_o;
	logic [XLEN-1:0] bcast_data_o, commit_data_o, flush_pc_o;
	logic [4:0] commit_rd_o;

	// model of the buffer
	logic m_valid [DEPTH];
	logic m_rdy [DEPTH];
	rob_pkg::opcode_e m_op [DEPTH];
	logic [XLEN-1:0] m_pc [DEPTH];
	logic [XLEN-1:0] m_target [DEPTH];
	logic [XLEN-1:0] m_data [DEPTH];
	logic [4:0] m_rd [DEPTH];
	logic m_pred [DEPTH];
	logic [TAG_W-1:0] m_head, m_tail;
	int m_count;
	logic flush_seen;
	integer seed;
	string test_name;
	rob_pkg::opcode_e plain_ops [8];

	rob_top rob_top_inst (
		.clk(clk), .rst(rst), .iq_valid_i(iq_valid_i), .iq_opcode_i(iq_opcode_i),
		.iq_pc_i(iq_pc_i), .iq_rd_i(iq_rd_i), .iq_br_pred_i(iq_br_pred_i),
		.iq_target_i(iq_target_i), .stall_br_i(stall_i[0]), .stall_acu_i(stall_i[1]),
		.stall_lsq_i(stall_i[2]), .iq_deq_o(iq_deq_o), .load_br_o(load_o[0]),
		.load_acu_o(load_o[1]), .load_lsq_o(load_o[2]), .reg_write_o(reg_write_o),
		.dispatch_tag_o(dispatch_tag_o), .free_count_o(free_count_o),
		.acu_cpl_valid_i(u_valid[1]), .acu_cpl_tag_i(u_tag[1]), .acu_cpl_data_i(u_data[1]),
		.acu_cpl_ready_o(u_ready[1]), .br_cpl_valid_i(u_valid[0]), .br_cpl_tag_i(u_tag[0]),
		.br_cpl_data_i(u_data[0]), .br_cpl_ready_o(u_ready[0]),
		.lsq_cpl_valid_i(u_valid[2]), .lsq_cpl_tag_i(u_tag[2]), .lsq_cpl_data_i(u_data[2]),
		.lsq_cpl_ready_o(u_ready[2]), .bcast_valid_o(bcast_valid_o),
		.bcast_tag_o(bcast_tag_o), .bcast_data_o(bcast_data_o),
		.commit_valid_o(commit_valid_o), .commit_tag_o(commit_tag_o),
		.commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o),
		.commit_we_o(commit_we_o), .flush_o(flush_o), .flush_pc_o(flush_pc_o)
	);

	always #(PERIOD / 2) clk = ~clk;

	// routing table
	function automatic int unit_for(rob_pkg::opcode_e op);
		if (op == rob_pkg::op_br || op == rob_pkg::op_jal || op == rob_pkg::op_jalr) return 0;
		if (op == rob_pkg::op_load || op == rob_pkg::op_store) return 2;
		return 1;
	endfunction

	function automatic logic writes_for(rob_pkg::opcode_e op);
		return op != rob_pkg::op_br && op != rob_pkg::op_store;
	endfunction

	// value recorded and committed for a completion
	function automatic logic [XLEN-1:0] record_for(rob_pkg::opcode_e op, logic [XLEN-1:0] pc,
			logic [XLEN-1:0] data);
		if (op == rob_pkg::op_jal || op == rob_pkg::op_jalr) return pc + 4;
		return data;
	endfunction

	function automatic logic redirect_for(rob_pkg::opcode_e op, logic pred, logic [XLEN-1:0] data);
		if (op == rob_pkg::op_jalr) return 1'b1;
		return op == rob_pkg::op_br && data[0] != pred;
	endfunction

	function automatic logic [XLEN-1:0] redirect_pc(rob_pkg::opcode_e op, logic [XLEN-1:0] pc,
			logic [XLEN-1:0] target, logic [XLEN-1:0] data);
		if (op == rob_pkg::op_jalr) return data;
		return data[0] ? target : pc + 4;
	endfunction

	task automatic check(string what, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		if (exp !== act) begin
			$display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic abort_run(string why);
		$display("%s during %s", why, test_name);
		$display("Regression failed");
		$fatal(1);
	endtask

	// compares DUT outputs with the model mid-cycle once everything has settled
	always @(negedge clk) begin
		int n;
		int g;
		logic exp_commit;
		logic exp_bc;
		logic exp_fl;
		logic [XLEN-1:0] rec;
		logic [TAG_W-1:0] t;
		logic [TAG_W-1:0] ftag;
		if (!rst) begin
			check("free_count", 32'(DEPTH - m_count), 32'(free_count_o));
			exp_commit = m_valid[m_head] && m_rdy[m_head];
			check("commit_valid", 32'(exp_commit), 32'(commit_valid_o));
			if (exp_commit) begin
				check("commit_tag", 32'(m_head), 32'(commit_tag_o));
				check("commit_rd", 32'(m_rd[m_head]), 32'(commit_rd_o));
				check("commit_data", m_data[m_head], commit_data_o);
				check("commit_we", 32'(writes_for(m_op[m_head])), 32'(commit_we_o));
			end
			n = 0;
			g = -1;
			for (int u = 0; u < 3; u++) begin
				u_accepted[u] = u_valid[u] && u_ready[u];
				if (u_ready[u]) begin
					n++;
					g = u;
					check("ready without valid", 32'(1), 32'(u_valid[u]));
				end
			end
			check("ready count at most one", 32'(1), 32'(n <= 1));
			exp_bc = 1'b0;
			exp_fl = 1'b0;
			ftag = '0;
			if (g >= 0 && m_valid[u_tag[g]]) begin
				t = u_tag[g];
				rec = record_for(m_op[t], m_pc[t], u_data[g]);
				exp_bc = m_op[t] != rob_pkg::op_br;
				exp_fl = g == 0 && redirect_for(m_op[t], m_pred[t], u_data[g]);
				if (exp_bc) begin
					check("bcast_tag", 32'(t), 32'(bcast_tag_o));
					check("bcast_data", rec, bcast_data_o);
				end
				if (exp_fl) begin
					check("flush_pc", redirect_pc(m_op[t], m_pc[t], m_target[t], u_data[g]),
						flush_pc_o);
					ftag = t + 1'b1;
				end
				m_rdy[t] = 1'b1;
				m_data[t] = rec;
			end
			check("bcast_valid", 32'(exp_bc), 32'(bcast_valid_o));
			check("flush", 32'(exp_fl), 32'(flush_o));
			if (iq_deq_o) begin
				check("dispatch_tag", 32'(m_tail), 32'(dispatch_tag_o));
				check("dispatch during flush", 32'(0), 32'(flush_o));
				check("dispatch into full buffer", 32'(1), 32'(m_count < DEPTH || exp_commit));
				check("stalled unit accepted", 32'(0), 32'(stall_i[unit_for(iq_opcode_i)]));
				check("reg_write", 32'(writes_for(iq_opcode_i)), 32'(reg_write_o));
			end
			for (int u = 0; u < 3; u++) begin
				check("load select", 32'(iq_deq_o && unit_for(iq_opcode_i) == u), 32'(load_o[u]));
			end
			if (exp_commit) begin
				m_valid[m_head] = 1'b0;
				m_head = m_head + 1'b1;
				m_count--;
			end
			if (exp_fl) begin
				flush_seen = 1'b1;
				for (t = ftag; t != m_tail; t = t + 1'b1) begin
					m_valid[t] = 1'b0;
					m_count--;
				end
				m_tail = ftag;
			end else if (iq_deq_o) begin
				m_valid[m_tail] = 1'b1;
				m_rdy[m_tail] = 1'b0;
				m_op[m_tail] = iq_opcode_i;
				m_pc[m_tail] = iq_pc_i;
				m_rd[m_tail] = iq_rd_i;
				m_pred[m_tail] = iq_br_pred_i;
				m_target[m_tail] = iq_target_i;
				m_tail = m_tail + 1'b1;
				m_count++;
			end
		end
	end

	// execution units hold each completion until it is taken
	always @(posedge clk) begin
		#1;
		for (int u = 0; u < 3; u++) begin
			if (rst) begin
				u_valid[u] = 1'b0;
				cpl_q[u].delete();
			end else begin
				if (u_valid[u] && u_accepted[u]) begin
					u_valid[u] = 1'b0;
				end
				if (!u_valid[u] && cpl_q[u].size() > 0) begin
					{u_tag[u], u_data[u]} = cpl_q[u].pop_front();
					u_valid[u] = 1'b1;
				end
			end
		end
	end

	initial begin
		#(NUM_TESTS * CYCLES_PER_TEST * PERIOD);
		abort_run("watchdog expired");
	end

	task automatic wait_accept();
		int guard;
		guard = 0;
		do begin
			@(negedge clk);
			guard++;
			if (guard > 100) abort_run("instruction never accepted");
		end while (!iq_deq_o);
		@(posedge clk);
		#1;
		iq_valid_i = 1'b0;
	endtask

	task automatic present(rob_pkg::opcode_e op, logic pred);
		iq_valid_i = 1'b1;
		iq_opcode_i = op;
		iq_pc_i = $random(seed) & 32'hffff_fffc;
		iq_target_i = $random(seed) & 32'hffff_fffc;
		iq_rd_i = 5'($random(seed));
		iq_br_pred_i = pred;
	endtask

	task automatic dispatch_instr(rob_pkg::opcode_e op, logic pred);
		present(op, pred);
		wait_accept();
	endtask

	task automatic complete_tag(logic [TAG_W-1:0] tag, logic [XLEN-1:0] data);
		cpl_q[unit_for(m_op[tag])].push_back({tag, data});
	endtask

	// completes every live entry in random order and waits for the buffer to drain
	task automatic finish_all();
		logic [TAG_W-1:0] tags [$];
		logic [TAG_W-1:0] tmp;
		int j;
		int guard;
		for (int i = 0; i < DEPTH; i++) begin
			if (m_valid[i] && !m_rdy[i]) tags.push_back(TAG_W'(i));
		end
		for (int i = tags.size() - 1; i > 0; i--) begin
			j = int'({$random(seed)} % (i + 1));
			tmp = tags[i];
			tags[i] = tags[j];
			tags[j] = tmp;
		end
		foreach (tags[i]) begin
			if (m_op[tags[i]] == rob_pkg::op_br) begin
				complete_tag(tags[i], {$random(seed)} & ~32'h1 | 32'(m_pred[tags[i]]));
			end else begin
				complete_tag(tags[i], $random(seed));
			end
		end
		guard = 0;
		while (m_count != 0 || u_valid[0] || u_valid[1] || u_valid[2] ||
				cpl_q[0].size() + cpl_q[1].size() + cpl_q[2].size() != 0) begin
			@(posedge clk);
			#1;
			guard++;
			if (guard > 300) abort_run("buffer did not drain");
		end
	endtask

	task automatic wait_flush();
		int guard;
		guard = 0;
		while (!flush_seen) begin
			@(posedge clk);
			#1;
			guard++;
			if (guard > 50) abort_run("no flush after a redirecting branch");
		end
	endtask

	initial begin
		seed = 32'h6285_1463;
		clk = 1'b0;
		rst = 1'b1;
		iq_valid_i = 1'b0;
		iq_opcode_i = rob_pkg::op_imm;
		iq_pc_i = '0;
		iq_rd_i = '0;
		iq_br_pred_i = 1'b0;
		iq_target_i = '0;
		flush_seen = 1'b0;
		m_head = '0;
		m_tail = '0;
		m_count = 0;
		test_name = "reset";
		plain_ops = '{rob_pkg::op_lui, rob_pkg::op_auipc, rob_pkg::op_jal, rob_pkg::op_br,
			rob_pkg::op_load, rob_pkg::op_store, rob_pkg::op_imm, rob_pkg::op_reg};
		for (int u = 0; u < 3; u++) begin
			stall_i[u] = 1'b0;
			u_valid[u] = 1'b0;
			u_tag[u] = '0;
			u_data[u] = '0;
			u_accepted[u] = 1'b0;
		end
		for (int i = 0; i < DEPTH; i++) begin
			m_valid[i] = 1'b0;
			m_rdy[i] = 1'b0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		test_name = "routing";
		repeat (4) begin
			repeat (6) dispatch_instr(plain_ops[{$random(seed)} % 8], 1'($random(seed)));
			finish_all();
		end
		present(rob_pkg::op_jal, 1'b0);
		stall_i[0] = 1'b1;
		repeat (3) begin
			@(negedge clk);
			check("deq while stalled", 32'(0), 32'(iq_deq_o));
		end
		@(posedge clk);
		#1;
		stall_i[0] = 1'b0;
		wait_accept();
		finish_all();

		test_name = "full";
		repeat (8) dispatch_instr(rob_pkg::op_reg, 1'b0);
		present(rob_pkg::op_imm, 1'b0);
		repeat (4) begin
			@(negedge clk);
			check("deq while full", 32'(0), 32'(iq_deq_o));
		end
		@(posedge clk);
		#1;
		complete_tag(m_head, $random(seed));
		wait_accept();
		finish_all();

		test_name = "in_order";
		repeat (3) begin
			repeat (8) dispatch_instr(plain_ops[{$random(seed)} % 8], 1'($random(seed)));
			finish_all();
		end

		test_name = "arbitration";
		repeat (3) begin
			for (int i = 0; i < 8; i++) begin
				dispatch_instr(i % 3 == 0 ? rob_pkg::op_jal :
					(i % 3 == 1 ? rob_pkg::op_imm : rob_pkg::op_load), 1'b0);
			end
			finish_all();
		end

		test_name = "mispredict";
		flush_seen = 1'b0;
		dispatch_instr(rob_pkg::op_br, 1'b0);
		repeat (3) dispatch_instr(rob_pkg::op_imm, 1'b0);
		complete_tag(m_tail - 3'd4, 32'h1);
		wait_flush();
		finish_all();
		dispatch_instr(rob_pkg::op_reg, 1'b0);
		dispatch_instr(rob_pkg::op_br, 1'b1);
		finish_all();
		flush_seen = 1'b0;
		dispatch_instr(rob_pkg::op_br, 1'b1);
		repeat (2) dispatch_instr(rob_pkg::op_load, 1'b0);
		complete_tag(m_tail - 2'd3, 32'h0);
		wait_flush();
		finish_all();

		test_name = "jalr";
		flush_seen = 1'b0;
		dispatch_instr(rob_pkg::op_imm, 1'b0);
		dispatch_instr(rob_pkg::op_jalr, 1'b0);
		repeat (2) dispatch_instr(rob_pkg::op_reg, 1'b0);
		complete_tag(m_tail - 3'd3, $random(seed) & 32'hffff_fffc);
		wait_flush();
		finish_all();

		$display("Regression passed");
		$finish;
	end

endmodule
